//--- src.f
+incdir+testbench
rtl/cpu_pkg.sv
rtl/branch_predictor.sv
rtl/fetch_unit.sv
rtl/if_id_register.sv
rtl/register_file.sv
rtl/execute_unit.sv
rtl/cpu_core.sv
testbench/tb_cpu_core.sv

//--- run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it, and judge the log
verilator --binary --timing -f src.f --top-module tb_cpu_core -o sim_cpu_core \
        > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }
./obj_dir/sim_cpu_core > sim.log 2>&1
grep -q "Checks failed" sim.log && { echo "simulation FAILED, see sim.log"; exit 1; }
grep -q "All checks passed" sim.log || { echo "simulation did not finish"; exit 1; }
echo "simulation passed"

//--- testbench/tb_tests.svh
`ifndef TB_TESTS_SVH
`define TB_TESTS_SVH

localparam logic [3:0] BNE = 4'd0;
localparam logic [3:0] BEQ = 4'd1;
localparam logic [3:0] BGZ = 4'd2;
localparam logic [3:0] BLZ = 4'd3;
localparam logic [3:0] ADI = 4'd4;
localparam logic [5:0] FUNC_ADD = 6'd0;
localparam logic [5:0] FUNC_SUB = 6'd1;
localparam logic [5:0] FUNC_JPR = 6'd25;
localparam logic [5:0] FUNC_WWD = 6'd28;
localparam logic [5:0] FUNC_HLT = 6'd29;
localparam logic [1:0] R0 = 2'd0;
localparam logic [1:0] R1 = 2'd1;
localparam logic [1:0] R2 = 2'd2;
localparam logic [1:0] R3 = 2'd3;

function automatic logic [15:0] rtype_word(input logic [1:0] rs, input logic [1:0] rt,
                                          input logic [1:0] rd, input logic [5:0] fn);
        return {4'hF, rs, rt, rd, fn};
endfunction

function automatic logic [15:0] itype_word(input logic [3:0] op, input logic [1:0] rs,
                                          input logic [1:0] rt, input logic [7:0] imm);
        return {op, rs, rt, imm};
endfunction

function automatic logic [15:0] jump_word(input logic [11:0] target);
        return {4'h9, target};
endfunction

function automatic logic [15:0] wwd_word(input logic [1:0] rs);
        return rtype_word(rs, R0, R0, FUNC_WWD);
endfunction

function automatic logic [15:0] sign_ext(input logic [7:0] v);
        return {{8{v[7]}}, v};
endfunction

task automatic load_program();
        // filler ADI carries its own address so runaway fetches stand out
        for (int a = 0; a < MEM_WORDS; a++)
                imem[a] = itype_word(ADI, R0, R0, a[7:0]);
        foreach (prog[n])
                imem[n] = prog[n];
endtask

task automatic reset_dut();
        @(negedge clk);
        reset_n = 1'b1;
        repeat (4) @(negedge clk);
        reset_n = 1'b0;
endtask

// load, reset, then gather WWD words until the core halts
task automatic run_program();
        int cycles;
        outputs.delete();
        load_program();
        reset_dut();
        cycles = 0;
        while (!is_halted) begin
                @(negedge clk);
                if (output_valid)
                        outputs.push_back(output_port);
                cycles++;
                if (cycles >= HALT_TIMEOUT && !is_halted) begin
                        $display("program never halted within %0d cycles", HALT_TIMEOUT);
                        abort_run();
                end
        end
endtask

task automatic compare_results(input string name, input int insts, input int misses);
        check_value(32'(outputs.size()), 32'(expected.size()), {name, " output count"});
        foreach (expected[n])
                check_value(32'(outputs[n]), 32'(expected[n]),
                            $sformatf("%s output %0d", name, n));
        check_value(32'(num_inst), 32'(insts), {name, " instruction count"});
        check_value(32'(num_branch_miss), 32'(misses), {name, " miss count"});
endtask

task automatic arithmetic_ops();
        logic [7:0] a;
        logic [7:0] b;
        a = 8'($urandom());
        b = 8'($urandom());
        prog.delete();
        prog.push_back(itype_word(ADI, R0, R1, a));
        prog.push_back(itype_word(ADI, R0, R2, b));
        prog.push_back(rtype_word(R1, R2, R3, FUNC_ADD));
        prog.push_back(wwd_word(R3));
        prog.push_back(rtype_word(R1, R2, R3, FUNC_SUB));
        prog.push_back(wwd_word(R3));
        prog.push_back(wwd_word(R1));
        prog.push_back(rtype_word(R0, R0, R0, FUNC_HLT));
        expected.delete();
        expected.push_back(sign_ext(a) + sign_ext(b));
        expected.push_back(sign_ext(a) - sign_ext(b));
        expected.push_back(sign_ext(a));
        run_program();
        compare_results("arithmetic", prog.size(), 0);
endtask

task automatic counted_loop();
        int k;
        k = int'($urandom_range(2, 6));
        prog.delete();
        prog.push_back(itype_word(ADI, R0, R1, 8'(k)));    // loop bound
        prog.push_back(itype_word(ADI, R2, R2, 8'd1));     // loop top at 1
        prog.push_back(wwd_word(R2));
        prog.push_back(itype_word(BNE, R2, R1, 8'hFD));    // back to 1
        prog.push_back(itype_word(ADI, R2, R3, 8'd100));
        prog.push_back(wwd_word(R3));
        prog.push_back(rtype_word(R0, R0, R0, FUNC_HLT));
        expected.delete();
        for (int i = 1; i <= k; i++)
                expected.push_back(16'(i));
        expected.push_back(16'(k + 100));
        run_program();
        // first taken pass and the final exit both mispredict
        compare_results("counted loop", 3 * k + 4, 2);
endtask

task automatic jump_in_loop();
        int k;
        k = int'($urandom_range(2, 6));
        prog.delete();
        prog.push_back(itype_word(ADI, R0, R1, 8'(k)));
        prog.push_back(itype_word(ADI, R2, R2, 8'd1));
        prog.push_back(jump_word(12'd4));
        prog.push_back(wwd_word(R1));                      // jumped over
        prog.push_back(wwd_word(R2));
        prog.push_back(itype_word(BNE, R2, R1, 8'hFB));
        prog.push_back(rtype_word(R0, R0, R0, FUNC_HLT));
        expected.delete();
        for (int i = 1; i <= k; i++)
                expected.push_back(16'(i));
        run_program();
        compare_results("jump loop", 4 * k + 2, 3);
endtask

task automatic branch_conditions();
        logic [7:0] p;
        logic [7:0] n;
        p = 8'($urandom_range(1, 100));
        n = 8'(0 - $urandom_range(1, 100));
        prog.delete();
        prog.push_back(itype_word(ADI, R0, R1, p));
        prog.push_back(itype_word(ADI, R0, R2, n));
        prog.push_back(itype_word(BEQ, R1, R2, 8'd1));     // p never equals n
        prog.push_back(wwd_word(R1));
        prog.push_back(itype_word(BGZ, R2, R0, 8'd1));
        prog.push_back(wwd_word(R2));
        prog.push_back(itype_word(BLZ, R1, R0, 8'd1));
        prog.push_back(wwd_word(R1));
        prog.push_back(rtype_word(R0, R0, R0, FUNC_HLT));
        expected.delete();
        expected.push_back(sign_ext(p));
        expected.push_back(sign_ext(n));
        expected.push_back(sign_ext(p));
        run_program();
        compare_results("branches not taken", 9, 0);

        prog.delete();
        prog.push_back(itype_word(ADI, R0, R1, p));
        prog.push_back(itype_word(ADI, R0, R2, n));
        prog.push_back(itype_word(BEQ, R1, R1, 8'd1));
        prog.push_back(wwd_word(R2));
        prog.push_back(itype_word(BGZ, R1, R0, 8'd1));
        prog.push_back(wwd_word(R2));
        prog.push_back(itype_word(BLZ, R2, R0, 8'd1));
        prog.push_back(wwd_word(R2));
        prog.push_back(wwd_word(R1));
        prog.push_back(rtype_word(R0, R0, R0, FUNC_HLT));
        expected.delete();
        expected.push_back(sign_ext(p));
        run_program();
        compare_results("branches taken", 7, 3);
endtask

task automatic register_jump_and_halt();
        logic [7:0]  v;
        logic [15:0] port_seen;
        logic [15:0] insts_seen;
        v = 8'($urandom());
        prog.delete();
        prog.push_back(itype_word(ADI, R0, R1, 8'd4));     // jump address
        prog.push_back(itype_word(ADI, R0, R2, v));
        prog.push_back(rtype_word(R1, R0, R0, FUNC_JPR));
        prog.push_back(wwd_word(R1));
        prog.push_back(wwd_word(R2));
        prog.push_back(rtype_word(R0, R0, R0, FUNC_HLT));
        prog.push_back(wwd_word(R1));                      // waits behind the halt
        expected.delete();
        expected.push_back(sign_ext(v));
        run_program();
        compare_results("register jump", 5, 1);
        port_seen  = output_port;
        insts_seen = num_inst;
        check_value(32'(port_seen), 32'(sign_ext(v)), "output port after halt");
        repeat (20) begin
                @(negedge clk);
                check_value(32'(is_halted), 32'd1, "halt flag held");
                check_value(32'(output_valid), 32'd0, "no output after halt");
                check_value(32'(output_port), 32'(port_seen), "output port frozen");
                check_value(32'(num_inst), 32'(insts_seen), "instruction count frozen");
        end
endtask

`endif

//--- testbench/tb_cpu_core.sv
`timescale 1ns/100ps

module tb_cpu_core;

        localparam int MEM_WORDS    = 256;
        localparam int HALT_TIMEOUT = 500;

        logic        clk;
        logic        reset_n;
        logic [15:0] i_data;
        logic [15:0] i_address;
        logic [15:0] output_port;
        logic        output_valid;
        logic        is_halted;
        logic [15:0] num_inst;
        logic [15:0] num_branch_miss;

        logic [15:0] imem [MEM_WORDS];
        logic [15:0] prog [$];          // program built by the running test
        logic [15:0] outputs [$];       // WWD words in the order they came out
        logic [15:0] expected [$];

        cpu_core #(
                .BTB_IDX_W (3)
        ) u_cpu_core (
                .clk               (clk),
                .reset_n           (reset_n),
                .i_i_data          (i_data),
                .o_i_address       (i_address),
                .o_output_port     (output_port),
                .o_output_valid    (output_valid),
                .o_is_halted       (is_halted),
                .o_num_inst        (num_inst),
                .o_num_branch_miss (num_branch_miss)
        );

        initial begin
                clk = 1'b0;
                forever #2 clk = ~clk;
        end

        // instruction memory answers half a cycle after the pc moves
        initial begin
                i_data = '0;
                forever begin
                        @(negedge clk);
                        i_data = imem[i_address[7:0]];
                end
        end

        task automatic abort_run();
                $display("Checks failed");
                $fatal(1, "simulation stopped at the first error");
        endtask

        task automatic check_value(input logic [31:0] actual, input logic [31:0] want,
                                   input string what);
                if (actual !== want) begin
                        $display("[FAIL] %0t: %s, got %0h, expected %0h", $time, what, actual,
                                 want);
                        abort_run();
                end
        endtask

        `include "tb_tests.svh"

        initial begin
                reset_n = 1'b1;
                void'($urandom(32'h464a));
                arithmetic_ops();
                counted_loop();
                jump_in_loop();
                branch_conditions();
                register_jump_and_halt();
                $display("All checks passed");
                $finish;
        end

endmodule

//--- rtl/cpu_core.sv
`timescale 1ns/100ps

module cpu_core
        import cpu_pkg::*;
#(
        parameter int BTB_IDX_W = 3
) (
        input  logic  clk,
        input  logic  reset_n,
        input  word_t i_i_data,
        output word_t o_i_address,
        output word_t o_output_port,
        output logic  o_output_valid,
        output logic  o_is_halted,
        output word_t o_num_inst,
        output word_t o_num_branch_miss
);

        fetch_pkt_t if_pkt;
        fetch_pkt_t id_pkt;
        bp_update_t bp_update;
        word_t      redirect_pc;
        logic       redirect;
        logic       halted;

        fetch_unit #(
                .BTB_IDX_W (BTB_IDX_W)
        ) u_fetch_unit (
                .clk           (clk),
                .reset_n       (reset_n),
                .i_instr       (i_i_data),
                .i_redirect    (redirect),
                .i_redirect_pc (redirect_pc),
                .i_halted      (halted),
                .i_update      (bp_update),
                .o_pc          (o_i_address),
                .o_fetch       (if_pkt)
        );

        // a mispredict kills the word fetched behind it
        if_id_register u_if_id_register (
                .clk     (clk),
                .reset_n (reset_n),
                .i_flush (redirect),
                .i_hold  (halted),
                .i_fetch (if_pkt),
                .o_fetch (id_pkt)
        );

        execute_unit u_execute_unit (
                .clk               (clk),
                .reset_n           (reset_n),
                .i_fetch           (id_pkt),
                .o_redirect        (redirect),
                .o_redirect_pc     (redirect_pc),
                .o_update          (bp_update),
                .o_halted          (halted),
                .o_output_port     (o_output_port),
                .o_output_valid    (o_output_valid),
                .o_num_inst        (o_num_inst),
                .o_num_branch_miss (o_num_branch_miss)
        );

        assign o_is_halted = halted;

endmodule

//--- rtl/execute_unit.sv
`timescale 1ns/100ps

module execute_unit
        import cpu_pkg::*;
(
        input  logic       clk,
        input  logic       reset_n,
        input  fetch_pkt_t i_fetch,
        output logic       o_redirect,
        output word_t      o_redirect_pc,
        output bp_update_t o_update,
        output logic       o_halted,
        output word_t      o_output_port,
        output logic       o_output_valid,
        output word_t      o_num_inst,
        output word_t      o_num_branch_miss
);

        instr_u    ins;
        opcode_t   opcode;
        func_t     func;
        word_t     rs_data;
        word_t     rt_data;
        word_t     imm_ext;
        word_t     pc_plus1;
        word_t     alu_result;
        word_t     ctrl_target;
        word_t     actual_pc;
        reg_addr_t wr_addr;
        logic      exec_valid;
        logic      is_rtype, is_adi, is_branch, is_jmp, is_jpr, is_wwd, is_hlt;
        logic      cond, taken, wr_en, miss;
        logic      halted_q;

        assign ins    = i_fetch.instr;
        assign opcode = ins.r.opcode;
        assign func   = ins.r.func;

        assign exec_valid = i_fetch.valid && !halted_q;
        assign is_rtype   = (opcode == OP_RTYPE);
        assign is_adi     = (opcode == OP_ADI);
        assign is_branch  = opcode inside {OP_BNE, OP_BEQ, OP_BGZ, OP_BLZ};
        assign is_jmp     = (opcode == OP_JMP);
        assign is_jpr     = is_rtype && (func == FN_JPR);
        assign is_wwd     = is_rtype && (func == FN_WWD);
        assign is_hlt     = is_rtype && (func == FN_HLT);

        register_file u_register_file (
                .clk       (clk),
                .reset_n   (reset_n),
                .i_rs      (ins.i.rs),
                .i_rt      (ins.i.rt),
                .i_wr_addr (wr_addr),
                .i_wr_en   (wr_en),
                .i_wr_data (alu_result),
                .o_rs_data (rs_data),
                .o_rt_data (rt_data)
        );

        assign imm_ext    = {{(WORD_W-8){ins.i.imm[7]}}, ins.i.imm};
        assign pc_plus1   = i_fetch.pc + 1'b1;
        assign alu_result = is_adi ? rs_data + imm_ext :
                            (func == FN_SUB) ? rs_data - rt_data : rs_data + rt_data;
        assign wr_addr    = is_adi ? ins.i.rt : ins.r.rd;  // ADI writes rt
        assign wr_en      = exec_valid && (is_adi || (is_rtype && func inside {FN_ADD, FN_SUB}));

        always_comb begin
                case (opcode)
                        OP_BNE:  cond = (rs_data != rt_data);
                        OP_BEQ:  cond = (rs_data == rt_data);
                        OP_BGZ:  cond = ($signed(rs_data) > 0);
                        OP_BLZ:  cond = rs_data[WORD_W-1];
                        default: cond = 1'b0;
                endcase
        end

        always_comb begin
                taken       = 1'b0;
                ctrl_target = pc_plus1 + imm_ext;   // branch offset from pc+1
                if (is_branch) begin
                        taken = cond;
                end else if (is_jmp) begin
                        taken       = 1'b1;
                        ctrl_target = {pc_plus1[WORD_W-1:WORD_W-4], ins.j.target};
                end else if (is_jpr) begin
                        taken       = 1'b1;
                        ctrl_target = rs_data;
                end
        end

        assign actual_pc = taken ? ctrl_target : pc_plus1;
        assign miss      = exec_valid && (actual_pc != i_fetch.pred_pc);

        assign o_redirect    = miss;
        assign o_redirect_pc = actual_pc;

        // untracked not-taken branches leave the BTB alone
        assign o_update.valid  = exec_valid && (is_branch || is_jmp || is_jpr) &&
                                 (i_fetch.tag_match || taken);
        assign o_update.pc     = i_fetch.pc;
        assign o_update.target = ctrl_target;
        assign o_update.taken  = taken;

        always_ff @(posedge clk) begin
                if (reset_n) begin
                        halted_q          <= 1'b0;
                        o_output_valid    <= 1'b0;
                        o_num_inst        <= '0;
                        o_num_branch_miss <= '0;
                end else begin
                        o_output_valid <= exec_valid && is_wwd;   // one-cycle pulse
                        if (exec_valid) begin
                                o_num_inst <= o_num_inst + 1'b1;  // HLT counts too
                                if (is_hlt)
                                        halted_q <= 1'b1;
                        end
                        if (miss)
                                o_num_branch_miss <= o_num_branch_miss + 1'b1;
                end
        end

        always_ff @(posedge clk) begin
                if (exec_valid && is_wwd)
                        o_output_port <= rs_data;
        end

        assign o_halted = halted_q;

endmodule

//--- rtl/register_file.sv
`timescale 1ns/100ps

module register_file
        import cpu_pkg::*;
(
        input  logic      clk,
        input  logic      reset_n,
        input  reg_addr_t i_rs,
        input  reg_addr_t i_rt,
        input  reg_addr_t i_wr_addr,
        input  logic      i_wr_en,
        input  word_t     i_wr_data,
        output word_t     o_rs_data,
        output word_t     o_rt_data
);

        localparam int NUM_REGS = 1 << REG_ADDR_W;

        word_t regs [NUM_REGS];

        always_ff @(posedge clk) begin
                if (reset_n) begin
                        for (int k = 0; k < NUM_REGS; k++)
                                regs[k] <= '0;
                end else if (i_wr_en) begin
                        regs[i_wr_addr] <= i_wr_data;
                end
        end

        // a write lands in time for the next instruction
        assign o_rs_data = regs[i_rs];
        assign o_rt_data = regs[i_rt];

endmodule

//--- rtl/if_id_register.sv
`timescale 1ns/100ps

module if_id_register
        import cpu_pkg::*;
(
        input  logic       clk,
        input  logic       reset_n,
        input  logic       i_flush,
        input  logic       i_hold,
        input  fetch_pkt_t i_fetch,
        output fetch_pkt_t o_fetch
);

        fetch_pkt_t pkt_q;

        // flush and reset leave an empty slot
        always_ff @(posedge clk) begin
                if (reset_n) begin
                        pkt_q.valid <= 1'b0;
                end else if (i_flush) begin
                        pkt_q.valid <= 1'b0;      // wrong-path fetch
                end else if (!i_hold) begin
                        pkt_q <= i_fetch;
                end
        end

        assign o_fetch = pkt_q;

endmodule

//--- rtl/fetch_unit.sv
`timescale 1ns/100ps

module fetch_unit
        import cpu_pkg::*;
#(
        parameter int BTB_IDX_W = 3
) (
        input  logic       clk,
        input  logic       reset_n,
        input  word_t      i_instr,
        input  logic       i_redirect,
        input  word_t      i_redirect_pc,
        input  logic       i_halted,
        input  bp_update_t i_update,
        output word_t      o_pc,
        output fetch_pkt_t o_fetch
);

        word_t pc_q;
        word_t predicted_pc;
        logic  tag_match;

        branch_predictor #(
                .BTB_IDX_W (BTB_IDX_W)
        ) u_branch_predictor (
                .clk            (clk),
                .reset_n        (reset_n),
                .i_pc           (pc_q),
                .i_update       (i_update),
                .o_predicted_pc (predicted_pc),
                .o_tag_match    (tag_match)
        );

        always_ff @(posedge clk) begin
                if (reset_n) begin
                        pc_q <= '0;
                end else if (i_redirect) begin
                        pc_q <= i_redirect_pc;    // mispredict fixed up in execute
                end else if (!i_halted) begin
                        pc_q <= predicted_pc;
                end
        end

        assign o_pc = pc_q;

        // memory word for pc_q arrives during this cycle
        always_comb begin
                o_fetch.valid     = ~i_halted;
                o_fetch.pc        = pc_q;
                o_fetch.pred_pc   = predicted_pc;
                o_fetch.instr     = i_instr;
                o_fetch.tag_match = tag_match;
        end

endmodule

//--- rtl/branch_predictor.sv
`timescale 1ns/100ps

module branch_predictor
        import cpu_pkg::*;
#(
        parameter int BTB_IDX_W = 3
) (
        input  logic       clk,
        input  logic       reset_n,
        input  word_t      i_pc,
        input  bp_update_t i_update,
        output word_t      o_predicted_pc,
        output logic       o_tag_match
);

        localparam int BTB_DEPTH = 1 << BTB_IDX_W;

        word_t                btb_tag    [BTB_DEPTH];
        word_t                btb_target [BTB_DEPTH];
        logic [1:0]           btb_cnt    [BTB_DEPTH];   // 2-bit saturating counters
        logic [BTB_DEPTH-1:0] btb_valid;

        logic [BTB_IDX_W-1:0] rd_idx;
        logic [BTB_IDX_W-1:0] up_idx;
        logic                 up_hit;
        logic                 alloc;

        // lookup for the pc being fetched
        assign rd_idx      = i_pc[BTB_IDX_W-1:0];
        assign o_tag_match = btb_valid[rd_idx] && (btb_tag[rd_idx] == i_pc);

        // weakly or strongly taken
        assign o_predicted_pc = (o_tag_match && btb_cnt[rd_idx][1]) ? btb_target[rd_idx]
                                                                     : i_pc + 1'b1;

        assign up_idx = i_update.pc[BTB_IDX_W-1:0];
        assign up_hit = btb_valid[up_idx] && (btb_tag[up_idx] == i_update.pc);
        assign alloc  = i_update.valid && !up_hit && i_update.taken;  // new taken branch

        always_ff @(posedge clk) begin
                if (reset_n) begin
                        btb_valid <= '0;
                end else if (alloc) begin
                        btb_valid[up_idx] <= 1'b1;
                end
        end

        always_ff @(posedge clk) begin
                if (i_update.valid && up_hit) begin
                        if (i_update.taken) begin
                                if (btb_cnt[up_idx] != 2'd3)
                                        btb_cnt[up_idx] <= btb_cnt[up_idx] + 2'd1;
                                btb_target[up_idx] <= i_update.target;  // JPR may move
                        end else if (btb_cnt[up_idx] != 2'd0) begin
                                btb_cnt[up_idx] <= btb_cnt[up_idx] - 2'd1;
                        end
                end else if (alloc) begin
                        btb_tag[up_idx]    <= i_update.pc;
                        btb_target[up_idx] <= i_update.target;
                        btb_cnt[up_idx]    <= 2'd2;           // start weakly taken
                end
        end

endmodule

//--- rtl/cpu_pkg.sv
package cpu_pkg;

        localparam int WORD_W     = 16;
        localparam int REG_ADDR_W = 2;

        typedef logic [WORD_W-1:0]     word_t;
        typedef logic [REG_ADDR_W-1:0] reg_addr_t;

        typedef enum logic [3:0] {
                OP_BNE   = 4'd0,
                OP_BEQ   = 4'd1,
                OP_BGZ   = 4'd2,
                OP_BLZ   = 4'd3,
                OP_ADI   = 4'd4,
                OP_JMP   = 4'd9,
                OP_RTYPE = 4'd15
        } opcode_t;

        // only meaningful when opcode is OP_RTYPE
        typedef enum logic [5:0] {
                FN_ADD = 6'd0,
                FN_SUB = 6'd1,
                FN_JPR = 6'd25,
                FN_WWD = 6'd28,
                FN_HLT = 6'd29
        } func_t;

        typedef struct packed {
                opcode_t   opcode;
                reg_addr_t rs;
                reg_addr_t rt;
                reg_addr_t rd;
                func_t     func;
        } r_type_t;

        typedef struct packed {
                opcode_t    opcode;
                reg_addr_t  rs;
                reg_addr_t  rt;
                logic [7:0] imm;      // signed branch offset or ADI operand
        } i_type_t;

        typedef struct packed {
                opcode_t     opcode;
                logic [11:0] target;
        } j_type_t;

        // one instruction word read three ways
        typedef union packed {
                r_type_t r;
                i_type_t i;
                j_type_t j;
        } instr_u;

        typedef struct packed {
                logic   valid;
                word_t  pc;
                word_t  pred_pc;      // next pc as guessed in fetch
                instr_u instr;
                logic   tag_match;
        } fetch_pkt_t;

        typedef struct packed {
                logic  valid;
                word_t pc;
                word_t target;
                logic  taken;
        } bp_update_t;

endpackage
